/* design/gbc_io_pkg.sv */
`default_nettype none

package gbc_io_pkg;

    // ==================================================
    // Widths
    // ==================================================
    typedef logic [15:0] io_addr_t;
    typedef logic [7:0]  io_data_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;
    typedef logic [1:0]  axi_resp_t;
    // Bit 3 (serial) never set in this block
    typedef logic [4:0]  irq_vec_t;

    // ==================================================
    // Register map
    // ==================================================
    localparam io_addr_t ADDR_SB   = 16'hFF01;
    localparam io_addr_t ADDR_SC   = 16'hFF02;
    localparam io_addr_t ADDR_DIV  = 16'hFF04;
    localparam io_addr_t ADDR_TIMA = 16'hFF05;
    localparam io_addr_t ADDR_TMA  = 16'hFF06;
    localparam io_addr_t ADDR_TAC  = 16'hFF07;
    localparam io_addr_t ADDR_IF   = 16'hFF0F;
    localparam io_addr_t ADDR_IE   = 16'hFFFF;

    // AXI response codes
    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // Interrupt bit positions in IF and IE
    localparam int IRQ_VBLANK  = 0;
    localparam int IRQ_LCDSTAT = 1;
    localparam int IRQ_TIMER   = 2;
    localparam int IRQ_JOYPAD  = 4;

    localparam int HEARTBEAT_WIDTH_DEFAULT = 8;

endpackage

`default_nettype wire

/* design/axil_io_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_io_slave (
    input  logic                  clock_in,
    input  logic                  synch_reset,
    // AXI4-Lite write channels
    input  logic [31:0]           awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  gbc_io_pkg::axi_data_t wdata,
    input  gbc_io_pkg::axi_strb_t wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic                  bvalid,
    output gbc_io_pkg::axi_resp_t bresp,
    input  logic                  bready,
    // AXI4-Lite read channels
    input  logic [31:0]           araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic                  rvalid,
    output gbc_io_pkg::axi_data_t rdata,
    output gbc_io_pkg::axi_resp_t rresp,
    input  logic                  rready,
    // Register bus
    output gbc_io_pkg::io_addr_t  reg_addr,
    output gbc_io_pkg::io_data_t  reg_wdata,
    output logic                  reg_we,
    output logic                  reg_re,
    input  gbc_io_pkg::io_data_t  reg_rdata,
    input  logic                  addr_hit
);

    import gbc_io_pkg::*;

    logic wr_go;
    logic rd_go;

    // ==================================================
    // Handshake and arbitration
    // ==================================================

    // Write needs both address and data, and no response waiting
    assign wr_go = awvalid && wvalid && !bvalid;

    // Read yields to a write in the same cycle
    assign rd_go = arvalid && !rvalid && !wr_go;

    assign awready = wr_go;
    assign wready  = wr_go;
    assign arready = rd_go;

    // Only one side drives the register bus in a given cycle
    assign reg_addr  = wr_go ? awaddr[15:0] : araddr[15:0];
    assign reg_wdata = wdata[7:0];
    assign reg_we    = wr_go && wstrb[0];
    assign reg_re    = rd_go;

    // ==================================================
    // Write response
    // ==================================================
    always_ff @(posedge clock_in) begin
        if (synch_reset) begin
            bvalid <= 1'b0;
            bresp  <= RESP_OKAY;
        end else if (wr_go) begin
            bvalid <= 1'b1;
            bresp  <= addr_hit ? RESP_OKAY : RESP_SLVERR;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    // ==================================================
    // Read response
    // ==================================================
    always_ff @(posedge clock_in) begin
        if (synch_reset) begin
            rvalid <= 1'b0;
            rdata  <= '0;
            rresp  <= RESP_OKAY;
        end else if (rd_go) begin
            rvalid <= 1'b1;
            // Register value sits in byte lane 0
            rdata  <= {24'h000000, reg_rdata};
            rresp  <= addr_hit ? RESP_OKAY : RESP_SLVERR;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* design/io_register_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module io_register_bank (
    input  logic                 clock_in,
    input  logic                 synch_reset,
    input  gbc_io_pkg::io_addr_t reg_addr,
    input  gbc_io_pkg::io_data_t reg_wdata,
    input  logic                 reg_we,
    input  logic                 reg_re,
    output gbc_io_pkg::io_data_t reg_rdata,
    output logic                 addr_hit,
    input  gbc_io_pkg::io_data_t tim_rdata,
    input  gbc_io_pkg::io_data_t if_rdata,
    input  gbc_io_pkg::io_data_t ie_rdata,
    output logic                 timer_sel_we,
    output logic                 if_we,
    output logic                 ie_we,
    output gbc_io_pkg::io_data_t sb_value
);

    import gbc_io_pkg::*;

    logic     sel_sb, sel_sc, sel_tim, sel_if, sel_ie;
    io_data_t sb_q;
    logic     sc_start;
    logic     sc_clk_int;

    // Address decode
    assign sel_sb  = (reg_addr == ADDR_SB);
    assign sel_sc  = (reg_addr == ADDR_SC);
    assign sel_tim = (reg_addr == ADDR_DIV) || (reg_addr == ADDR_TIMA) ||
                     (reg_addr == ADDR_TMA) || (reg_addr == ADDR_TAC);
    assign sel_if  = (reg_addr == ADDR_IF);
    assign sel_ie  = (reg_addr == ADDR_IE);

    assign addr_hit = sel_sb || sel_sc || sel_tim || sel_if || sel_ie;

    // Write strobes for the other register owners
    assign timer_sel_we = reg_we && sel_tim;
    assign if_we        = reg_we && sel_if;
    assign ie_we        = reg_we && sel_ie;

    // ==================================================
    // Serial registers
    // ==================================================
    always_ff @(posedge clock_in) begin
        if (synch_reset) begin
            sb_q       <= '0;
            sc_start   <= 1'b0;
            sc_clk_int <= 1'b0;
        end else if (reg_we) begin
            if (sel_sb)
                sb_q <= reg_wdata;
            if (sel_sc) begin
                sc_start   <= reg_wdata[7];
                sc_clk_int <= reg_wdata[0];
            end
        end
    end

    assign sb_value = sb_q;

    // Read mux, 0xFF when nothing is addressed
    always_comb begin
        reg_rdata = 8'hFF;
        if (reg_re) begin
            if (sel_sb)
                reg_rdata = sb_q;
            else if (sel_sc)
                reg_rdata = {sc_start, 6'b111111, sc_clk_int};
            else if (sel_tim)
                reg_rdata = tim_rdata;
            else if (sel_if)
                reg_rdata = if_rdata;
            else if (sel_ie)
                reg_rdata = ie_rdata;
        end
    end

endmodule

`default_nettype wire

/* design/timer_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module timer_unit (
    input  logic                 clock_in,
    input  logic                 synch_reset,
    input  gbc_io_pkg::io_addr_t reg_addr,
    input  gbc_io_pkg::io_data_t reg_wdata,
    input  logic                 timer_sel_we,
    output gbc_io_pkg::io_data_t tim_rdata,
    output logic                 timer_req
);

    import gbc_io_pkg::*;

    logic [15:0] div_cnt;
    io_data_t    tima;
    io_data_t    tma;
    logic [2:0]  tac;
    logic        tap_bit;
    logic        tap_prev;
    logic        tick;
    logic        wr_div, wr_tima, wr_tma, wr_tac;

    // Timer registers differ only in the two low address bits
    assign wr_div  = timer_sel_we && (reg_addr[1:0] == ADDR_DIV[1:0]);
    assign wr_tima = timer_sel_we && (reg_addr[1:0] == ADDR_TIMA[1:0]);
    assign wr_tma  = timer_sel_we && (reg_addr[1:0] == ADDR_TMA[1:0]);
    assign wr_tac  = timer_sel_we && (reg_addr[1:0] == ADDR_TAC[1:0]);

    // ==================================================
    // Divider and tap select
    // ==================================================
    always_ff @(posedge clock_in) begin
        if (synch_reset || wr_div)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 16'd1;
    end

    always_comb begin
        case (tac[1:0])
            2'b00:   tap_bit = div_cnt[9];
            2'b01:   tap_bit = div_cnt[3];
            2'b10:   tap_bit = div_cnt[5];
            default: tap_bit = div_cnt[7];
        endcase
    end

    // Count on the falling edge of the gated tap
    assign tick = tap_prev && !(tap_bit && tac[2]);

    // ==================================================
    // TIMA, TMA, TAC
    // ==================================================
    always_ff @(posedge clock_in) begin
        if (synch_reset) begin
            tap_prev  <= 1'b0;
            tima      <= '0;
            tma       <= '0;
            tac       <= '0;
            timer_req <= 1'b0;
        end else begin
            tap_prev  <= tap_bit && tac[2];
            timer_req <= 1'b0;
            if (wr_tma)
                tma <= reg_wdata;
            if (wr_tac)
                tac <= reg_wdata[2:0];
            if (wr_tima) begin
                tima <= reg_wdata;
            end else if (tick) begin
                if (tima == 8'hFF) begin
                    // Overflow reloads from TMA
                    tima      <= tma;
                    timer_req <= 1'b1;
                end else begin
                    tima <= tima + 8'd1;
                end
            end
        end
    end

    always_comb begin
        case (reg_addr[1:0])
            ADDR_DIV[1:0]:  tim_rdata = div_cnt[15:8];
            ADDR_TIMA[1:0]: tim_rdata = tima;
            ADDR_TMA[1:0]:  tim_rdata = tma;
            default:        tim_rdata = {5'b11111, tac};
        endcase
    end

endmodule

`default_nettype wire

/* design/interrupt_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module interrupt_ctrl (
    input  logic                 clock_in,
    input  logic                 synch_reset,
    input  gbc_io_pkg::io_data_t reg_wdata,
    input  logic                 if_we,
    input  logic                 ie_we,
    input  logic                 timer_req,
    input  logic                 vblank_req,
    input  logic                 lcdstat_req,
    input  logic                 joypad_req,
    output gbc_io_pkg::io_data_t if_rdata,
    output gbc_io_pkg::io_data_t ie_rdata,
    output logic                 irq
);

    import gbc_io_pkg::*;

    // Sources that exist here, serial is left out
    localparam irq_vec_t IRQ_MASK = irq_vec_t'((1 << IRQ_VBLANK) | (1 << IRQ_LCDSTAT) |
                                               (1 << IRQ_TIMER) | (1 << IRQ_JOYPAD));

    irq_vec_t req_vec;
    irq_vec_t if_q;
    io_data_t ie_q;

    always_comb begin
        req_vec              = '0;
        req_vec[IRQ_VBLANK]  = vblank_req;
        req_vec[IRQ_LCDSTAT] = lcdstat_req;
        req_vec[IRQ_TIMER]   = timer_req;
        req_vec[IRQ_JOYPAD]  = joypad_req;
    end

    // ==================================================
    // IF and IE
    // ==================================================
    always_ff @(posedge clock_in) begin
        if (synch_reset) begin
            if_q <= '0;
            ie_q <= '0;
        end else begin
            // New requests win over a clearing write
            if (if_we)
                if_q <= (reg_wdata[4:0] & IRQ_MASK) | req_vec;
            else
                if_q <= if_q | req_vec;
            if (ie_we)
                ie_q <= reg_wdata;
        end
    end

    assign if_rdata = {3'b111, if_q};
    assign ie_rdata = ie_q;

    assign irq = |(if_q & ie_q[4:0]);

endmodule

`default_nettype wire

/* design/debug_led_driver.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_led_driver #(
    parameter int HEARTBEAT_WIDTH = gbc_io_pkg::HEARTBEAT_WIDTH_DEFAULT
) (
    input  logic                 clock_in,
    input  logic                 synch_reset,
    input  logic                 led_select,
    input  gbc_io_pkg::io_data_t sb_value,
    output gbc_io_pkg::io_data_t led
);

    import gbc_io_pkg::*;

    logic [HEARTBEAT_WIDTH-1:0] hb_cnt;
    io_data_t                   hb_byte;
    io_data_t                   sb_q;

    // Heartbeat byte steps once per counter wrap
    always_ff @(posedge clock_in) begin
        if (synch_reset) begin
            hb_cnt  <= '0;
            hb_byte <= '0;
            sb_q    <= '0;
        end else begin
            hb_cnt <= hb_cnt + 1'b1;
            if (hb_cnt == '1)
                hb_byte <= hb_byte + 8'd1;
            sb_q <= sb_value;
        end
    end

    assign led = led_select ? hb_byte : sb_q;

endmodule

`default_nettype wire

/* design/gbc_io_top.sv */
`timescale 1ns/1ps
`default_nettype none

module gbc_io_top #(
    parameter int HEARTBEAT_WIDTH = gbc_io_pkg::HEARTBEAT_WIDTH_DEFAULT
) (
    input  logic                  clock_in,
    input  logic                  synch_reset,
    input  logic [31:0]           awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  gbc_io_pkg::axi_data_t wdata,
    input  gbc_io_pkg::axi_strb_t wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic                  bvalid,
    output gbc_io_pkg::axi_resp_t bresp,
    input  logic                  bready,
    input  logic [31:0]           araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic                  rvalid,
    output gbc_io_pkg::axi_data_t rdata,
    output gbc_io_pkg::axi_resp_t rresp,
    input  logic                  rready,
    input  logic                  vblank_req,
    input  logic                  lcdstat_req,
    input  logic                  joypad_req,
    input  logic                  led_select,
    output gbc_io_pkg::io_data_t  led,
    output logic                  irq
);

    import gbc_io_pkg::*;

    // ==================================================
    // Internal nets
    // ==================================================
    io_addr_t reg_addr;
    io_data_t reg_wdata;
    io_data_t reg_rdata;
    logic     reg_we;
    logic     reg_re;
    logic     addr_hit;
    io_data_t tim_rdata;
    io_data_t if_rdata;
    io_data_t ie_rdata;
    logic     timer_sel_we;
    logic     if_we;
    logic     ie_we;
    logic     timer_req;
    io_data_t sb_value;

    // ==================================================
    // Instances
    // ==================================================
    axil_io_slave slave0 (
        .clock_in(clock_in), .synch_reset(synch_reset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bresp(bresp), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
        .reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_we(reg_we),
        .reg_re(reg_re), .reg_rdata(reg_rdata), .addr_hit(addr_hit)
    );

    io_register_bank bank0 (
        .clock_in(clock_in), .synch_reset(synch_reset),
        .reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_we(reg_we),
        .reg_re(reg_re), .reg_rdata(reg_rdata), .addr_hit(addr_hit),
        .tim_rdata(tim_rdata), .if_rdata(if_rdata), .ie_rdata(ie_rdata),
        .timer_sel_we(timer_sel_we), .if_we(if_we), .ie_we(ie_we),
        .sb_value(sb_value)
    );

    timer_unit timer0 (
        .clock_in(clock_in), .synch_reset(synch_reset),
        .reg_addr(reg_addr), .reg_wdata(reg_wdata),
        .timer_sel_we(timer_sel_we), .tim_rdata(tim_rdata),
        .timer_req(timer_req)
    );

    interrupt_ctrl intr0 (
        .clock_in(clock_in), .synch_reset(synch_reset),
        .reg_wdata(reg_wdata), .if_we(if_we), .ie_we(ie_we),
        .timer_req(timer_req), .vblank_req(vblank_req),
        .lcdstat_req(lcdstat_req), .joypad_req(joypad_req),
        .if_rdata(if_rdata), .ie_rdata(ie_rdata), .irq(irq)
    );

    debug_led_driver #(
        .HEARTBEAT_WIDTH(HEARTBEAT_WIDTH)
    ) led0 (
        .clock_in(clock_in), .synch_reset(synch_reset),
        .led_select(led_select), .sb_value(sb_value), .led(led)
    );

endmodule

`default_nettype wire

/* testbench/tb_gbc_io_tasks.svh */
`ifndef TB_GBC_IO_TASKS_SVH
`define TB_GBC_IO_TASKS_SVH

// Codes for the bus flags that wait_flag can watch
localparam int F_AWREADY = 0;
localparam int F_ARREADY = 1;
localparam int F_BVALID  = 2;
localparam int F_RVALID  = 3;

function automatic logic bus_flag(input int sel);
    case (sel)
        F_AWREADY: return awready;
        F_ARREADY: return arready;
        F_BVALID:  return bvalid;
        default:   return rvalid;
    endcase
endfunction

// Sampled on the falling edge, away from the driving edge
task automatic wait_flag(input int sel, input string what);
    int cnt;
    cnt = 0;
    @(negedge clock_in);
    while (!bus_flag(sel)) begin
        if (cnt >= HS_TIMEOUT)
            end_with_timeout(what);
        cnt++;
        @(negedge clock_in);
    end
endtask

// ==================================================
// AXI4-Lite single transfers
// ==================================================
task automatic axi_write(input io_addr_t addr, input axi_data_t data,
                         input axi_strb_t strb, output axi_resp_t resp);
    @(posedge clock_in);
    awaddr  <= {16'h0000, addr};
    wdata   <= data;
    wstrb   <= strb;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    bready  <= 1'b1;
    wait_flag(F_AWREADY, "awready");
    @(posedge clock_in);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    wait_flag(F_BVALID, "bvalid");
    resp = bresp;
    @(posedge clock_in);
    bready <= 1'b0;
endtask

task automatic axi_read(input io_addr_t addr, output axi_data_t data,
                        output axi_resp_t resp);
    @(posedge clock_in);
    araddr  <= {16'h0000, addr};
    arvalid <= 1'b1;
    rready  <= 1'b1;
    wait_flag(F_ARREADY, "arready");
    @(posedge clock_in);
    arvalid <= 1'b0;
    wait_flag(F_RVALID, "rvalid");
    data = rdata;
    resp = rresp;
    @(posedge clock_in);
    rready <= 1'b0;
endtask

// Value checks
task automatic check_eq(input string name, input axi_data_t got, input axi_data_t exp);
    assert (got === exp) else begin
        $display("[ERROR] %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
        test_errors++;
    end
endtask

task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
        $display("%0t ns: %s", $time, what);
        test_errors++;
    end
endtask

`endif

/* testbench/tb_gbc_io.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_gbc_io;

    import gbc_io_pkg::*;

    localparam int HS_TIMEOUT = 200;
    localparam int EV_TIMEOUT = 5000;
    localparam int MAX_ROWS   = 48;

    // Row kinds of the stimulus table
    localparam int OP_WRITE   = 0;
    localparam int OP_READ    = 1;
    localparam int OP_READ_GE = 2;
    localparam int OP_READ_LT = 3;
    localparam int OP_REQ     = 4;
    localparam int OP_LED_SB  = 5;
    localparam int OP_LED_HB  = 6;
    localparam int OP_IRQ_WT  = 7;
    localparam int OP_IRQ_CHK = 8;
    localparam int OP_BP      = 9;
    localparam int OP_DIV_WT  = 10;

    logic      clock_in, synch_reset;
    logic      [31:0] awaddr, araddr;
    logic      awvalid, awready, wvalid, wready, bvalid, bready;
    logic      arvalid, arready, rvalid, rready;
    axi_data_t wdata, rdata;
    axi_strb_t wstrb;
    axi_resp_t bresp, rresp;
    logic      vblank_req, lcdstat_req, joypad_req, led_select, irq;
    io_data_t  led;

    int        row_test [MAX_ROWS];
    int        row_kind [MAX_ROWS];
    io_addr_t  row_addr [MAX_ROWS];
    axi_data_t row_data [MAX_ROWS];
    axi_strb_t row_strb [MAX_ROWS];
    axi_data_t row_exp  [MAX_ROWS];
    axi_resp_t row_resp [MAX_ROWS];
    int        n_rows;
    int        test_errors, total_errors, tests_run, tests_failed;
    integer    seed;

    gbc_io_top #(
        .HEARTBEAT_WIDTH(4)
    ) dut0 (
        .clock_in(clock_in), .synch_reset(synch_reset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bresp(bresp), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
        .vblank_req(vblank_req), .lcdstat_req(lcdstat_req), .joypad_req(joypad_req),
        .led_select(led_select), .led(led), .irq(irq)
    );

    initial begin
        clock_in = 1'b0;
        forever #20 clock_in = ~clock_in;
    end

    task automatic end_with_timeout(input string what);
        $display("Timeout: %s never came within %0d cycles", what, HS_TIMEOUT);
        $display("test failed");
        $finish;
    endtask

    `include "tb_gbc_io_tasks.svh"

    task automatic add_row(input int t, input int kind, input io_addr_t addr,
                           input axi_data_t data, input axi_data_t exp,
                           input axi_resp_t resp);
        row_test[n_rows] = t;
        row_kind[n_rows] = kind;
        row_addr[n_rows] = addr;
        row_data[n_rows] = data;
        row_strb[n_rows] = 4'hF;
        row_exp[n_rows]  = exp;
        row_resp[n_rows] = resp;
        n_rows++;
    endtask

    // ==================================================
    // Stimulus table
    // ==================================================
    task automatic build_table();
        axi_data_t rnd;
        io_data_t  sb_r, sc_r, ie_r;
        rnd  = $random(seed);
        sb_r = rnd[7:0];
        rnd  = $random(seed);
        sc_r = rnd[7:0];
        rnd  = $random(seed);
        ie_r = rnd[7:0];
        n_rows = 0;
        add_row(1, OP_WRITE, ADDR_SB, sb_r, 0, RESP_OKAY);
        add_row(1, OP_READ, ADDR_SB, 0, sb_r, RESP_OKAY);
        add_row(1, OP_WRITE, ADDR_SC, sc_r, 0, RESP_OKAY);
        add_row(1, OP_READ, ADDR_SC, 0, {sc_r[7], 6'h3F, sc_r[0]}, RESP_OKAY);
        add_row(1, OP_WRITE, ADDR_IE, ie_r, 0, RESP_OKAY);
        add_row(1, OP_READ, ADDR_IE, 0, ie_r, RESP_OKAY);
        add_row(1, OP_LED_SB, 0, 0, sb_r, RESP_OKAY);
        add_row(1, OP_LED_HB, 0, 0, 0, RESP_OKAY);
        // Unmapped space, then a write with lane 0 masked off
        add_row(2, OP_WRITE, 16'hFF03, 8'h12, 0, RESP_SLVERR);
        add_row(2, OP_READ, 16'hFF50, 0, 8'hFF, RESP_SLVERR);
        add_row(2, OP_WRITE, ADDR_SB, ~sb_r, 0, RESP_OKAY);
        row_strb[n_rows-1] = 4'b1110;
        add_row(2, OP_READ, ADDR_SB, 0, sb_r, RESP_OKAY);
        add_row(3, OP_WRITE, ADDR_TMA, 8'h3C, 0, RESP_OKAY);
        add_row(3, OP_READ, ADDR_TMA, 0, 8'h3C, RESP_OKAY);
        add_row(3, OP_WRITE, ADDR_TAC, 8'h02, 0, RESP_OKAY);
        add_row(3, OP_READ, ADDR_TAC, 0, 8'hFA, RESP_OKAY);
        add_row(3, OP_WRITE, ADDR_IE, 8'h04, 0, RESP_OKAY);
        add_row(3, OP_WRITE, ADDR_TMA, 8'hF0, 0, RESP_OKAY);
        add_row(3, OP_WRITE, ADDR_TIMA, 8'hFC, 0, RESP_OKAY);
        add_row(3, OP_WRITE, ADDR_TAC, 8'h05, 0, RESP_OKAY);
        add_row(3, OP_IRQ_WT, 0, 0, 1, RESP_OKAY);
        add_row(3, OP_READ, ADDR_IF, 0, 8'hE4, RESP_OKAY);
        add_row(3, OP_READ_GE, ADDR_TIMA, 0, 8'hF0, RESP_OKAY);
        // Let DIV run past 0x01 before it is cleared
        add_row(3, OP_DIV_WT, ADDR_DIV, 0, 8'h02, RESP_OKAY);
        add_row(3, OP_WRITE, ADDR_DIV, 8'h00, 0, RESP_OKAY);
        add_row(3, OP_READ_LT, ADDR_DIV, 0, 8'h02, RESP_OKAY);
        // Timer stopped so that only the pulsed requests reach IF
        add_row(4, OP_WRITE, ADDR_TAC, 8'h00, 0, RESP_OKAY);
        add_row(4, OP_WRITE, ADDR_IF, 8'h00, 0, RESP_OKAY);
        add_row(4, OP_WRITE, ADDR_IE, 8'h00, 0, RESP_OKAY);
        add_row(4, OP_REQ, 0, 8'h01, 0, RESP_OKAY);
        add_row(4, OP_REQ, 0, 8'h02, 0, RESP_OKAY);
        add_row(4, OP_REQ, 0, 8'h10, 0, RESP_OKAY);
        add_row(4, OP_READ, ADDR_IF, 0, 8'hF3, RESP_OKAY);
        add_row(4, OP_IRQ_CHK, 0, 0, 0, RESP_OKAY);
        add_row(4, OP_WRITE, ADDR_IE, 8'h13, 0, RESP_OKAY);
        add_row(4, OP_IRQ_CHK, 0, 0, 1, RESP_OKAY);
        add_row(4, OP_WRITE, ADDR_IF, 8'h00, 0, RESP_OKAY);
        add_row(4, OP_IRQ_CHK, 0, 0, 0, RESP_OKAY);
        add_row(4, OP_READ, ADDR_IF, 0, 8'hE0, RESP_OKAY);
        add_row(5, OP_BP, ADDR_TMA, 8'h5A, 8'h5A, RESP_OKAY);
    endtask

    // Both responses held back while a second write and read wait
    task automatic run_backpressure(input io_addr_t addr, input io_data_t val);
        int i;
        @(posedge clock_in);
        awaddr  <= {16'h0000, addr};
        araddr  <= {16'h0000, addr};
        wdata   <= {24'h000000, val};
        wstrb   <= 4'hF;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        arvalid <= 1'b1;
        bready  <= 1'b0;
        rready  <= 1'b0;
        wait_flag(F_AWREADY, "awready");
        @(posedge clock_in);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        wait_flag(F_ARREADY, "arready");
        @(posedge clock_in);
        wdata   <= {24'h000000, ~val};
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        for (i = 0; i < 4; i++) begin
            @(negedge clock_in);
            check_eq("bvalid", bvalid, 1);
            check_eq("rvalid", rvalid, 1);
            check_eq("rdata", rdata, {24'h000000, val});
            check_eq("bresp", bresp, RESP_OKAY);
            check_eq("rresp", rresp, RESP_OKAY);
            check_eq("awready", awready, 0);
            check_eq("wready", wready, 0);
            check_eq("arready", arready, 0);
        end
        @(posedge clock_in);
        bready <= 1'b1;
        rready <= 1'b1;
        wait_flag(F_AWREADY, "awready");
        @(posedge clock_in);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        wait_flag(F_ARREADY, "arready");
        @(posedge clock_in);
        arvalid <= 1'b0;
        wait_flag(F_RVALID, "rvalid");
        check_eq("rdata", rdata, {24'h000000, ~val});
        @(posedge clock_in);
        bready <= 1'b0;
        rready <= 1'b0;
    endtask

    task automatic watch_heartbeat();
        io_data_t first;
        int       cnt;
        @(posedge clock_in);
        led_select <= 1'b1;
        @(negedge clock_in);
        first = led;
        cnt   = 0;
        while (led === first && cnt < EV_TIMEOUT) begin
            cnt++;
            @(negedge clock_in);
        end
        check_true(led !== first, "led did not change with led_select high");
        @(posedge clock_in);
        led_select <= 1'b0;
    endtask

    task automatic wait_irq(input logic level);
        int cnt;
        cnt = 0;
        @(negedge clock_in);
        while (irq !== level && cnt < EV_TIMEOUT) begin
            cnt++;
            @(negedge clock_in);
        end
        check_true(irq === level, "irq did not reach the expected level in time");
    endtask

    // Read DIV over the bus until it has climbed to min_val
    task automatic poll_div(input io_data_t min_val);
        axi_data_t got;
        axi_resp_t resp;
        int        cnt;
        cnt = 0;
        axi_read(ADDR_DIV, got, resp);
        while (got < min_val && cnt < EV_TIMEOUT) begin
            cnt++;
            axi_read(ADDR_DIV, got, resp);
        end
        check_true(got >= min_val, "DIV did not advance before the clearing write");
    endtask

    task automatic pulse_requests(input irq_vec_t mask);
        @(posedge clock_in);
        vblank_req  <= mask[IRQ_VBLANK];
        lcdstat_req <= mask[IRQ_LCDSTAT];
        joypad_req  <= mask[IRQ_JOYPAD];
        @(posedge clock_in);
        vblank_req  <= 1'b0;
        lcdstat_req <= 1'b0;
        joypad_req  <= 1'b0;
    endtask

    function automatic string test_name(input int t);
        case (t)
            1:       return "register readback and LED";
            2:       return "unmapped access and strobe";
            3:       return "timer";
            4:       return "interrupt requests";
            default: return "back-pressure";
        endcase
    endfunction

    task automatic finish_test(input int t);
        if (test_errors == 0) begin
            $display("Test %0d (%s): ok", t, test_name(t));
        end else begin
            $display("Test %0d (%s): %0d errors", t, test_name(t), test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        test_errors = 0;
        tests_run++;
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        int        r;
        axi_data_t got;
        axi_resp_t resp;
        seed = 98;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        synch_reset <= 1'b1;
        awaddr      <= '0;
        awvalid     <= 1'b0;
        wdata       <= '0;
        wstrb       <= '0;
        wvalid      <= 1'b0;
        bready      <= 1'b0;
        araddr      <= '0;
        arvalid     <= 1'b0;
        rready      <= 1'b0;
        vblank_req  <= 1'b0;
        lcdstat_req <= 1'b0;
        joypad_req  <= 1'b0;
        led_select  <= 1'b0;
        repeat (5) @(posedge clock_in);
        synch_reset <= 1'b0;
        build_table();

        for (r = 0; r < n_rows; r++) begin
            if (r > 0 && row_test[r] != row_test[r-1])
                finish_test(row_test[r-1]);
            case (row_kind[r])
                OP_WRITE: begin
                    axi_write(row_addr[r], row_data[r], row_strb[r], resp);
                    check_eq($sformatf("bresp[%h]", row_addr[r]), resp, row_resp[r]);
                end
                OP_READ: begin
                    axi_read(row_addr[r], got, resp);
                    check_eq($sformatf("rdata[%h]", row_addr[r]), got, row_exp[r]);
                    check_eq($sformatf("rresp[%h]", row_addr[r]), resp, row_resp[r]);
                end
                OP_READ_GE: begin
                    axi_read(row_addr[r], got, resp);
                    assert (got >= row_exp[r]) else begin
                        $display("[ERROR] %0t ns rdata[%h]: got 0x%0h, expected at least 0x%0h",
                                 $time, row_addr[r], got, row_exp[r]);
                        test_errors++;
                    end
                end
                OP_READ_LT: begin
                    axi_read(row_addr[r], got, resp);
                    assert (got < row_exp[r]) else begin
                        $display("[ERROR] %0t ns rdata[%h]: got 0x%0h, expected below 0x%0h",
                                 $time, row_addr[r], got, row_exp[r]);
                        test_errors++;
                    end
                end
                OP_REQ:    pulse_requests(row_data[r][4:0]);
                OP_LED_SB: begin
                    @(negedge clock_in);
                    check_eq("led", led, row_exp[r]);
                end
                OP_LED_HB: watch_heartbeat();
                OP_IRQ_WT: wait_irq(row_exp[r][0]);
                OP_IRQ_CHK: begin
                    @(negedge clock_in);
                    check_eq("irq", irq, row_exp[r]);
                end
                OP_DIV_WT: poll_div(row_exp[r][7:0]);
                default:   run_backpressure(row_addr[r], row_data[r][7:0]);
            endcase
        end
        finish_test(row_test[n_rows-1]);

        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* gbc_io.f */
+incdir+testbench
design/gbc_io_pkg.sv
design/axil_io_slave.sv
design/io_register_bank.sv
design/timer_unit.sv
design/interrupt_ctrl.sv
design/debug_led_driver.sv
design/gbc_io_top.sv
testbench/tb_gbc_io.sv

/* Bender.yml */
package:
  name: gbc_io

sources:
  - design/gbc_io_pkg.sv
  - design/axil_io_slave.sv
  - design/io_register_bank.sv
  - design/timer_unit.sv
  - design/interrupt_ctrl.sv
  - design/debug_led_driver.sv
  - design/gbc_io_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_gbc_io.sv
